//--- verilog/fft_macros.svh
// --------------------
// Frame size, widths and latency of the 16-point FFT
// --------------------
`ifndef FFT_MACROS_SVH
`define FFT_MACROS_SVH

// --------------------
// Frame geometry
// --------------------

// Points per frame
`define FFT_PTS 16

// Radix-2 stages per frame, also the RAM address width
`define FFT_LOG2 4

// --------------------
// Datapath widths
// --------------------

// Real or imaginary component of a sample
`define FFT_DW 16

// Twiddle component, Q1.14
`define FFT_TW 16

// --------------------
// Butterfly pipeline
// --------------------

// Cycles from request to result
`define FFT_BF_LAT 3

`endif

//--- verilog/fft_data_pkg.sv
// --------------------
// Data types of the FFT datapath
// Sample, complex sample and twiddle
// --------------------
`include "fft_macros.svh"

package fft_data_pkg;

	// --------------------
	// Samples
	// --------------------

	// One real or imaginary component, two's complement
	typedef logic signed [`FFT_DW-1:0] sample_t;

	// Complex sample
	// Real part in the upper half
	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	// --------------------
	// Twiddles
	// --------------------

	// Cosine or negative sine
	// Q1.14, so +1.0 is 16384
	typedef logic signed [`FFT_TW-1:0] twdl_t;

endpackage

//--- verilog/fft_ctrl_pkg.sv
// --------------------
// Control types of the FFT
// Sequencer state, addresses, butterfly request and result
// --------------------
`include "fft_macros.svh"

package fft_ctrl_pkg;

	// Frame RAM address
	typedef logic [`FFT_LOG2-1:0] addr_t;

	// Butterfly stage index
	typedef logic [1:0] stage_t;

	// Phases of one frame
	typedef enum logic [2:0] {
		IDLE,
		SINK,
		PROC,
		DRAIN,
		SOURCE
	} seq_state_t;

	// One butterfly issued to the core
	// Twiddle index selects W16 to that power
	typedef struct packed {
		logic                  valid;
		fft_data_pkg::cplx_t   a;
		fft_data_pkg::cplx_t   b;
		logic [`FFT_LOG2-2:0]  tw_idx;
		addr_t                 addr_a;
		addr_t                 addr_b;
	} bf_req_t;

	// Butterfly result with its write-back addresses
	typedef struct packed {
		logic                  valid;
		fft_data_pkg::cplx_t   a;
		fft_data_pkg::cplx_t   b;
		addr_t                 addr_a;
		addr_t                 addr_b;
	} bf_res_t;

endpackage

//--- verilog/fft_sink.sv
// --------------------
// Frame sink
// Four-phase receiver, writes samples to bit-reversed addresses
// --------------------
`include "fft_macros.svh"

module fft_sink (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 sink_en,
	input  logic                 in_req,
	input  fft_data_pkg::cplx_t  in_data,
	output logic                 in_ack,
	output logic                 wr_en,
	output fft_ctrl_pkg::addr_t  wr_addr,
	output fft_data_pkg::cplx_t  wr_data,
	output logic                 frame_full
);
	import fft_ctrl_pkg::*;

	// Responder states, ack is high in RX_ACK
	typedef enum logic {
		RX_WAIT,
		RX_ACK
	} rx_state_t;

	rx_state_t rx_state;
	addr_t     smp_cnt;
	logic      accept;

	// Mirror the address bits
	// DIT in place then leaves natural order
	function automatic addr_t bit_rev(input addr_t a);
		addr_t r;
		for (int i = 0; i < `FFT_LOG2; i++)
		begin
			r[i] = a[`FFT_LOG2-1-i];
		end
		return r;
	endfunction

	// New request while idle and the sequencer takes samples
	assign accept = (rx_state == RX_WAIT) && in_req && sink_en;
	assign in_ack = (rx_state == RX_ACK);

	// --------------------
	// Handshake and count
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rx_state   <= RX_WAIT;
			smp_cnt    <= '0;
			wr_en      <= 1'b0;
			frame_full <= 1'b0;
		end
		else
		begin
			// Write goes out with the rising ack
			wr_en <= accept;
			// Count wrapped to zero, so that was write 16
			frame_full <= wr_en && (smp_cnt == '0);
			case (rx_state)
				RX_WAIT:
					if (accept)
					begin
						rx_state <= RX_ACK;
						smp_cnt  <= smp_cnt + 1'b1;
					end
				RX_ACK:
					// Release once req has dropped
					if (!in_req)
						rx_state <= RX_WAIT;
				default:
					rx_state <= RX_WAIT;
			endcase
		end
	end

	// Captured sample and its scrambled slot
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			wr_addr <= bit_rev(smp_cnt);
			wr_data <= in_data;
		end
	end

	// Ack only ever answers a request seen the cycle before
	a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(in_ack) |-> $past(in_req))
		else $error("in_ack rose without in_req");

endmodule

//--- verilog/fft_bfly_rdx2.sv
// --------------------
// Radix-2 DIT butterfly, three pipeline stages
// Twiddle ROM, halving on every output
// --------------------
`include "fft_macros.svh"

module fft_bfly_rdx2 (
	input  logic                   clk,
	input  logic                   rst_n,
	input  fft_ctrl_pkg::bf_req_t  req,
	output fft_ctrl_pkg::bf_res_t  res
);
	import fft_data_pkg::*;
	import fft_ctrl_pkg::*;

	// Fraction bits of Q1.14
	localparam int TW_FRAC = `FFT_TW - 2;
	// Product kept two bits wider, |W*b| may exceed full scale
	localparam int PW = `FFT_DW + 2;

	// W16^k, cosine and negative sine, rounded
	localparam twdl_t COS_ROM [8] = '{16384, 15137, 11585, 6270,
		0, -6270, -11585, -15137};
	localparam twdl_t NSIN_ROM [8] = '{0, -6270, -11585, -15137,
		-16384, -15137, -11585, -6270};

	// Stage 1, operands and twiddle
	logic                     s1_vld;
	cplx_t                    s1_a;
	cplx_t                    s1_b;
	twdl_t                    s1_w_re;
	twdl_t                    s1_w_im;
	addr_t                    s1_addr_a;
	addr_t                    s1_addr_b;
	// Stage 2, rotated second operand
	logic                     s2_vld;
	cplx_t                    s2_a;
	logic signed [PW-1:0]     s2_p_re;
	logic signed [PW-1:0]     s2_p_im;
	addr_t                    s2_addr_a;
	addr_t                    s2_addr_b;
	// Stage 3, results
	logic                     r_vld;
	cplx_t                    r_a;
	cplx_t                    r_b;
	addr_t                    r_addr_a;
	addr_t                    r_addr_b;

	logic signed [`FFT_DW+`FFT_TW:0] mul_re;
	logic signed [`FFT_DW+`FFT_TW:0] mul_im;
	logic signed [PW:0]              sum_re;
	logic signed [PW:0]              sum_im;
	logic signed [PW:0]              dif_re;
	logic signed [PW:0]              dif_im;

	// Complex multiply b * W
	always_comb
	begin
		mul_re = s1_b.re * s1_w_re - s1_b.im * s1_w_im;
		mul_im = s1_b.re * s1_w_im + s1_b.im * s1_w_re;
	end

	always_comb
	begin
		sum_re = s2_a.re + s2_p_re;
		sum_im = s2_a.im + s2_p_im;
		dif_re = s2_a.re - s2_p_re;
		dif_im = s2_a.im - s2_p_im;
	end

	// --------------------
	// Valid pipe
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			s1_vld <= 1'b0;
			s2_vld <= 1'b0;
			r_vld  <= 1'b0;
		end
		else
		begin
			s1_vld <= req.valid;
			s2_vld <= s1_vld;
			r_vld  <= s2_vld;
		end
	end

	// Data and addresses, every cycle
	always_ff @(posedge clk)
	begin
		s1_a      <= req.a;
		s1_b      <= req.b;
		s1_w_re   <= COS_ROM[req.tw_idx];
		s1_w_im   <= NSIN_ROM[req.tw_idx];
		s1_addr_a <= req.addr_a;
		s1_addr_b <= req.addr_b;

		// Truncate back to integer scale
		s2_a      <= s1_a;
		s2_p_re   <= PW'(mul_re >>> TW_FRAC);
		s2_p_im   <= PW'(mul_im >>> TW_FRAC);
		s2_addr_a <= s1_addr_a;
		s2_addr_b <= s1_addr_b;

		// Arithmetic shift by one, then keep the low word
		r_a.re    <= sample_t'(sum_re >>> 1);
		r_a.im    <= sample_t'(sum_im >>> 1);
		r_b.re    <= sample_t'(dif_re >>> 1);
		r_b.im    <= sample_t'(dif_im >>> 1);
		r_addr_a  <= s2_addr_a;
		r_addr_b  <= s2_addr_b;
	end

	always_comb
	begin
		res.valid  = r_vld;
		res.a      = r_a;
		res.b      = r_b;
		res.addr_a = r_addr_a;
		res.addr_b = r_addr_b;
	end

endmodule

//--- verilog/fft_mem_seq.sv
// --------------------
// Frame RAM and phase sequencer
// Butterfly address generation, four-phase output source
// --------------------
`include "fft_macros.svh"

module fft_mem_seq (
	input  logic                   clk,
	input  logic                   rst_n,
	output logic                   sink_en,
	input  logic                   wr_en,
	input  fft_ctrl_pkg::addr_t    wr_addr,
	input  fft_data_pkg::cplx_t    wr_data,
	input  logic                   frame_full,
	output fft_ctrl_pkg::bf_req_t  bf_req,
	input  fft_ctrl_pkg::bf_res_t  bf_res,
	output logic                   out_req,
	input  logic                   out_ack,
	output fft_data_pkg::cplx_t    out_data
);
	import fft_data_pkg::*;
	import fft_ctrl_pkg::*;

	localparam int BF_PER_STAGE = `FFT_PTS / 2;
	localparam int TW_IW = `FFT_LOG2 - 1;
	localparam int DRN_W = $clog2(`FFT_BF_LAT + 1);

	seq_state_t        state;
	stage_t            stage;
	logic [TW_IW-1:0]  bf_cnt;
	logic [DRN_W-1:0]  drn_cnt;
	addr_t             src_cnt;
	// Ack seen high, waiting for it to fall
	logic              src_hold;

	// Pair addresses of the current butterfly
	logic [TW_IW-1:0]  low_mask;
	addr_t             pair_a;
	addr_t             pair_b;
	logic [TW_IW-1:0]  tw_idx;

	// Read port A
	logic              issue;
	logic              src_issue;
	logic              rd_en;
	addr_t             rd_addr_a;
	addr_t             rd_addr_b;
	cplx_t             rd_q_a;
	cplx_t             rd_q_b;
	logic              rd_vld;
	logic [TW_IW-1:0]  rd_tw;
	addr_t             rd_wb_a;
	addr_t             rd_wb_b;

	// Write port B
	logic              wb_en_a;
	logic              wb_en_b;
	addr_t             wb_addr_a;
	addr_t             wb_addr_b;
	cplx_t             wb_data_a;
	cplx_t             wb_data_b;

	cplx_t             ram [`FFT_PTS];

	assign sink_en = (state == IDLE) || (state == SINK);

	// --------------------
	// Butterfly addressing
	// --------------------
	always_comb
	begin
		// Span of one group is 2 << stage
		low_mask = TW_IW'((1 << stage) - 1);
		pair_a   = {bf_cnt & ~low_mask, 1'b0} | {1'b0, bf_cnt & low_mask};
		pair_b   = pair_a | (addr_t'(1) << stage);
		// Position in group, scaled to the W16 grid
		tw_idx   = (bf_cnt & low_mask) << (stage_t'(`FFT_LOG2 - 1) - stage);
	end

	// Port switches, as the frame moves between phases
	assign issue     = (state == PROC);
	assign src_issue = (state == SOURCE) && !out_req && !src_hold;
	assign rd_en     = issue || src_issue;
	assign rd_addr_a = (state == SOURCE) ? src_cnt : pair_a;
	assign rd_addr_b = pair_b;

	always_comb
	begin
		if (state == SINK)
		begin
			wb_en_a   = wr_en;
			wb_addr_a = wr_addr;
			wb_data_a = wr_data;
			wb_en_b   = 1'b0;
		end
		else
		begin
			wb_en_a   = bf_res.valid;
			wb_addr_a = bf_res.addr_a;
			wb_data_a = bf_res.a;
			wb_en_b   = bf_res.valid;
		end
		// Second lane only carries results
		wb_addr_b = bf_res.addr_b;
		wb_data_b = bf_res.b;
	end

	// Frame RAM, reads held between read strobes
	always_ff @(posedge clk)
	begin
		if (wb_en_a)
			ram[wb_addr_a] <= wb_data_a;
		if (wb_en_b)
			ram[wb_addr_b] <= wb_data_b;
		if (rd_en)
		begin
			rd_q_a <= ram[rd_addr_a];
			rd_q_b <= ram[rd_addr_b];
		end
	end

	// Side info follows the one-cycle read
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			rd_tw   <= tw_idx;
			rd_wb_a <= pair_a;
			rd_wb_b <= pair_b;
		end
	end

	always_comb
	begin
		bf_req.valid  = rd_vld;
		bf_req.a      = rd_q_a;
		bf_req.b      = rd_q_b;
		bf_req.tw_idx = rd_tw;
		bf_req.addr_a = rd_wb_a;
		bf_req.addr_b = rd_wb_b;
	end

	// Held steady by the read strobe
	assign out_data = rd_q_a;

	// --------------------
	// Phase FSM
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state    <= IDLE;
			stage    <= '0;
			bf_cnt   <= '0;
			drn_cnt  <= '0;
			src_cnt  <= '0;
			src_hold <= 1'b0;
			out_req  <= 1'b0;
			rd_vld   <= 1'b0;
		end
		else
		begin
			rd_vld <= issue;
			case (state)
				IDLE:
				begin
					stage   <= '0;
					bf_cnt  <= '0;
					drn_cnt <= '0;
					src_cnt <= '0;
					state   <= SINK;
				end
				SINK:
					if (frame_full)
						state <= PROC;
				PROC:
				begin
					// One butterfly per cycle
					bf_cnt <= bf_cnt + 1'b1;
					if (bf_cnt == TW_IW'(BF_PER_STAGE - 1))
						state <= DRAIN;
				end
				DRAIN:
				begin
					// Read latency plus pipeline depth
					drn_cnt <= drn_cnt + 1'b1;
					if (drn_cnt == DRN_W'(`FFT_BF_LAT))
					begin
						drn_cnt <= '0;
						stage   <= stage + 1'b1;
						state   <= (stage == stage_t'(`FFT_LOG2 - 1)) ? SOURCE : PROC;
					end
				end
				SOURCE:
				begin
					// req rises with the freshly read word
					if (src_issue)
						out_req <= 1'b1;
					if (out_req && out_ack)
					begin
						out_req  <= 1'b0;
						src_hold <= 1'b1;
					end
					if (src_hold && !out_ack)
					begin
						src_hold <= 1'b0;
						src_cnt  <= src_cnt + 1'b1;
						if (src_cnt == addr_t'(`FFT_PTS - 1))
							state <= IDLE;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Sink writes only land while collecting a frame
	a_sink_wr_phase: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> state == SINK)
		else $error("Sink write outside SINK phase");

	// Nothing left in the butterfly pipe between frames
	a_no_res_idle: assert property (@(posedge clk) disable iff (!rst_n)
		bf_res.valid |-> state != IDLE)
		else $error("Butterfly result arrived in IDLE");

endmodule

//--- verilog/fft_top.sv
// --------------------
// FFT top, sink, sequencer and butterfly
// --------------------

module fft_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_req,
	input  fft_data_pkg::cplx_t  in_data,
	output logic                 in_ack,
	output logic                 out_req,
	input  logic                 out_ack,
	output fft_data_pkg::cplx_t  out_data
);
	import fft_data_pkg::*;
	import fft_ctrl_pkg::*;

	// Sink to sequencer
	logic     sink_en;
	logic     wr_en;
	addr_t    wr_addr;
	cplx_t    wr_data;
	logic     frame_full;

	// Sequencer to butterfly and back
	bf_req_t  bf_req;
	bf_res_t  bf_res;

	// Input link
	fft_sink u_sink (
		.clk        (clk),
		.rst_n      (rst_n),
		.sink_en    (sink_en),
		.in_req     (in_req),
		.in_data    (in_data),
		.in_ack     (in_ack),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.frame_full (frame_full)
	);

	// RAM, phases and output link
	fft_mem_seq u_mem_seq (
		.clk        (clk),
		.rst_n      (rst_n),
		.sink_en    (sink_en),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.frame_full (frame_full),
		.bf_req     (bf_req),
		.bf_res     (bf_res),
		.out_req    (out_req),
		.out_ack    (out_ack),
		.out_data   (out_data)
	);

	fft_bfly_rdx2 u_bfly (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (bf_req),
		.res   (bf_res)
	);

endmodule

//--- testbench/tb_clkgen.sv
// --------------------
// Testbench clock, 40 ns period
// Synchronous reset held low for 3 cycles
// --------------------

module tb_clkgen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RST_CYCLES = 3;

	// Free-running clock
	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// Release on a rising edge, like any other stimulus
	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

//--- testbench/tb_fft_top.sv
// --------------------
// Testbench of the 16-point FFT
// Pattern reader, four-phase drivers, handshake checks
// Timeout and closing summary
// --------------------
`include "fft_macros.svh"

module tb_fft_top;
	timeunit 1ns;
	timeprecision 1ps;

	import fft_data_pkg::*;

	// Count word, inputs, expected outputs
	localparam int FRAME_WORDS = 1 + 2 * `FFT_PTS;
	localparam int PAT_WORDS = 512;
	localparam int CYC_PER_FRAME = 400;

	logic        clk;
	logic        rst_n;
	logic        in_req;
	cplx_t       in_data;
	logic        in_ack;
	logic        out_req;
	logic        out_ack;
	cplx_t       out_data;

	logic [31:0] pat_mem [PAT_WORDS];
	int          n_frames;
	int          frames_done;
	int          n_checked;
	int          val_errs;
	int          flow_errs;
	int          cycle_cnt;
	int          cycle_limit;
	logic [31:0] lfsr_state;

	// Link values from the previous edge
	logic        in_req_d;
	logic        in_ack_d;
	logic        out_req_d;
	logic        out_ack_d;
	cplx_t       out_data_d;

	tb_clkgen u_clkgen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	fft_top UUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_req   (in_req),
		.in_data  (in_data),
		.in_ack   (in_ack),
		.out_req  (out_req),
		.out_ack  (out_ack),
		.out_data (out_data)
	);

	// --------------------
	// Helpers
	// --------------------

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per bit
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	function automatic string frame_name(input int f);
		case (f)
			0: return "impulse_x0";
			1: return "tone_bin2";
			2: return "full_scale_mixed";
			3: return "impulse_x1";
			default: return "extra_frame";
		endcase
	endfunction

	// Frames run until a count word that is not 16
	task automatic load_patterns();
		int idx;
		$readmemh("testbench/fft_patterns.txt", pat_mem);
		n_frames = 0;
		idx = 0;
		while (idx + FRAME_WORDS < PAT_WORDS && pat_mem[idx] === 32'(`FFT_PTS))
		begin
			n_frames++;
			idx += FRAME_WORDS;
		end
		assert (n_frames > 0 && pat_mem[idx] === 32'h0)
		else
		begin
			$display("Pattern file has no frames or a bad count word at %0d", idx);
			flow_errs++;
		end
	endtask

	// Four-phase source for one sample
	task automatic send_sample(input int f, input logic [31:0] word);
		in_req  <= 1'b1;
		in_data <= word;
		do
			@(posedge clk);
		while (!in_ack);
		// Frame f is taken only after frame f-1 has left
		assert (frames_done >= f)
		else
		begin
			$display("in_ack for frame %0d came before frame %0d was fully read out",
				f, f - 1);
			flow_errs++;
		end
		in_req <= 1'b0;
		do
			@(posedge clk);
		while (in_ack);
	endtask

	task automatic drive_frames();
		int base;
		for (int f = 0; f < n_frames; f++)
		begin
			base = f * FRAME_WORDS + 1;
			for (int k = 0; k < `FFT_PTS; k++)
				send_sample(f, pat_mem[base + k]);
		end
	endtask

	// Four-phase sink for one output, random ack delay
	task automatic take_output(input int f, input int k, input cplx_t expected);
		cplx_t got;
		int    delay;
		do
			@(posedge clk);
		while (!out_req);
		got = out_data;
		n_checked++;
		assert (got === expected)
		else
		begin
			$display("ERR %s out[%0d]: expected %h, actual %h",
				frame_name(f), k, expected, got);
			val_errs++;
		end
		delay = take_bits(2);
		repeat (delay) @(posedge clk);
		out_ack <= 1'b1;
		do
			@(posedge clk);
		while (out_req);
		out_ack <= 1'b0;
	endtask

	task automatic collect_frames();
		int base;
		for (int f = 0; f < n_frames; f++)
		begin
			base = f * FRAME_WORDS + 1 + `FFT_PTS;
			for (int k = 0; k < `FFT_PTS; k++)
				take_output(f, k, pat_mem[base + k]);
			// 16th ack is dropping now
			frames_done++;
		end
	endtask

	task automatic finish_run();
		$display("Summary: %0d frames, %0d outputs checked, %0d value errors, %0d other errors",
			n_frames, n_checked, val_errs, flow_errs);
		if (val_errs == 0 && flow_errs == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	// --------------------
	// Handshake monitor
	// --------------------
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			if (in_ack && !in_ack_d)
				assert (in_req_d)
				else
				begin
					$display("in_ack rose while in_req was low");
					flow_errs++;
				end
			if (out_req_d && !out_req)
				assert (out_ack_d)
				else
				begin
					$display("out_req dropped before out_ack rose");
					flow_errs++;
				end
			if (out_req && !out_req_d)
				assert (!out_ack_d)
				else
				begin
					$display("out_req rose while out_ack was still high");
					flow_errs++;
				end
			if (out_req && out_req_d)
				assert (out_data === out_data_d)
				else
				begin
					$display("out_data changed while out_req was high");
					flow_errs++;
				end
		end
		in_req_d   = in_req;
		in_ack_d   = in_ack;
		out_req_d  = out_req;
		out_ack_d  = out_ack;
		out_data_d = out_data;
	end

	// Run limit scales with the number of frames
	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
		begin
			$display("Timeout, run still busy after %0d cycles", cycle_cnt);
			flow_errs++;
			finish_run();
		end
	end

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin
		in_req      = 1'b0;
		in_data     = '0;
		out_ack     = 1'b0;
		lfsr_state  = 32'h7bb3;
		frames_done = 0;
		n_checked   = 0;
		val_errs    = 0;
		flow_errs   = 0;
		cycle_cnt   = 0;
		cycle_limit = 0;
		load_patterns();
		cycle_limit = n_frames * CYC_PER_FRAME;

		// First edge out of reset, nothing driven yet
		do
			@(posedge clk);
		while (!rst_n);
		assert (in_ack === 1'b0 && out_req === 1'b0)
		else
		begin
			$display("Links not idle after reset, in_ack=%b out_req=%b", in_ack, out_req);
			flow_errs++;
		end

		// Input runs ahead, the sink holds it off
		if (n_frames > 0)
			fork
				drive_frames();
				collect_frames();
			join
		finish_run();
	end

endmodule

//--- testbench/fft_patterns.txt
// Per frame: count word (hex 10), 16 input words, then 16 expected outputs, 8 per line
// Word is {re, im}, each 16-bit two's complement; count 00 ends the list
// Impulse at x[0]
10
40000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
04000000 04000000 04000000 04000000 04000000 04000000 04000000 04000000
04000000 04000000 04000000 04000000 04000000 04000000 04000000 04000000
// Tone at bin 2, amplitude 8192
10
20000000 16A116A1 00002000 E95F16A1 E0000000 E95FE95F 0000E000 16A1E95F
20000000 16A116A1 00002000 E95F16A1 E0000000 E95FE95F 0000E000 16A1E95F
00000000 00000000 20000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// Full scale, alternating real part, constant imaginary part
10
7FFF8000 80008000 7FFF8000 80008000 7FFF8000 80008000 7FFF8000 80008000
7FFF8000 80008000 7FFF8000 80008000 7FFF8000 80008000 7FFF8000 80008000
FFFF8000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
7FFF0000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// Impulse at x[1], every twiddle in the last stage
10
00000000 40000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
04000000 03B2FE78 02D4FD2B 0187FC4D 0000FC00 FE78FC4D FD2BFD2B FC4DFE78
FC000000 FC4E0188 FD2C02D4 FE7803B2 00000400 018803B2 02D402D4 03B20188
// End of list
00

//--- sources.f
+incdir+verilog
verilog/fft_data_pkg.sv
verilog/fft_ctrl_pkg.sv
verilog/fft_sink.sv
verilog/fft_bfly_rdx2.sv
verilog/fft_mem_seq.sv
verilog/fft_top.sv
testbench/tb_clkgen.sv
testbench/tb_fft_top.sv

//--- Bender.yml
package:
  name: fft16_mem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fft_data_pkg.sv
      - verilog/fft_ctrl_pkg.sv
      - verilog/fft_sink.sv
      - verilog/fft_bfly_rdx2.sv
      - verilog/fft_mem_seq.sv
      - verilog/fft_top.sv
      - target: test
        files:
          - testbench/tb_clkgen.sv
          - testbench/tb_fft_top.sv
